// ==== long_pipe.f ====
source/long_pipe_pkg.sv
source/iter_unit_if.sv
source/imul_iterative.sv
source/idiv_iterative.sv
source/long_pipe.sv
source/long_pipe_top.sv
tb/long_pipe_properties.sv
tb/long_pipe_tb.sv

// ==== source/idiv_iterative.sv ====
`timescale 1ns/10ps

module idiv_iterative
  #(parameter int width_p = 64)
  (input logic          clk_i
  , input logic         arst_n_i
  , iter_unit_if.unit   u
  );

  typedef enum logic [1:0] {e_idle, e_busy, e_done} div_state_e;

  // counts width_p quotient bits, then one fix-up cycle
  localparam int cnt_width_lp = $clog2(width_p+1);

  localparam logic [width_p-1:0] min_val_lp = {1'b1, {(width_p-1){1'b0}}};

  div_state_e state_r, state_n;
  logic [cnt_width_lp-1:0] cnt_r;

  logic [width_p-1:0] dvsr_r;   // divisor magnitude
  logic [width_p-1:0] quo_r;    // dividend bits shift out, quotient bits shift in
  logic [width_p-1:0] rem_r;
  logic               q_neg_r;
  logic               r_neg_r;
  logic               zero_r;   // divide by zero
  logic               ovf_r;    // min / -1

  logic               start;
  logic               step;
  logic               fix;
  logic               a_neg;
  logic               b_neg;
  logic [width_p-1:0] mag_a;
  logic [width_p-1:0] mag_b;
  logic [width_p:0]   rem_shift;
  logic [width_p+1:0] diff;
  logic               q_bit;
  logic [width_p-1:0] rem_step;
  logic [width_p-1:0] quo_step;
  logic [width_p-1:0] q_signed;
  logic [width_p-1:0] r_signed;

  assign start = u.v & u.ready;
  assign step  = (state_r == e_busy) && (cnt_r != cnt_width_lp'(width_p));
  assign fix   = (state_r == e_busy) && (cnt_r == cnt_width_lp'(width_p));

  assign a_neg = u.signed_a & u.op_a[width_p-1];
  assign b_neg = u.signed_b & u.op_b[width_p-1];
  assign mag_a = a_neg ? -u.op_a : u.op_a;
  assign mag_b = b_neg ? -u.op_b : u.op_b;

  // --------------------
  // restoring step
  // --------------------

  assign rem_shift = {rem_r, quo_r[width_p-1]};
  assign diff      = {1'b0, rem_shift} - {2'b00, dvsr_r};
  assign q_bit     = ~diff[width_p+1];  // no borrow, keep the difference
  assign rem_step  = q_bit ? diff[width_p-1:0] : rem_shift[width_p-1:0];
  assign quo_step  = {quo_r[width_p-2:0], q_bit};

  // sign fix-up
  assign q_signed = q_neg_r ? -quo_r : quo_r;
  assign r_signed = r_neg_r ? -rem_r : rem_r;  // remainder follows the dividend

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle: if (start) state_n = e_busy;
      e_busy: if (fix) state_n = e_done;
      e_done: if (u.yumi) state_n = e_idle;
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (start)
        cnt_r <= '0;
      else if (step)
        cnt_r <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      dvsr_r  <= mag_b;
      quo_r   <= mag_a;
      rem_r   <= '0;
      q_neg_r <= a_neg ^ b_neg;
      r_neg_r <= a_neg;
      zero_r  <= (u.op_b == '0);
      ovf_r   <= u.signed_a & (u.op_a == min_val_lp) & (u.op_b == '1);
    end
    else if (step)
    begin
      quo_r <= quo_step;
      rem_r <= rem_step;
    end
    else if (fix)
    begin
      // remainder of a divide by zero is already the dividend after the sign fix
      if (zero_r)
        quo_r <= '1;
      else if (ovf_r)
        quo_r <= min_val_lp;
      else
        quo_r <= q_signed;
      rem_r <= ovf_r ? '0 : r_signed;
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign u.ready  = (state_r == e_idle);
  assign u.res_v  = (state_r == e_done);
  assign u.res_lo = quo_r;
  assign u.res_hi = rem_r;

endmodule

// ==== source/imul_iterative.sv ====
`timescale 1ns/10ps

module imul_iterative
  #(parameter int width_p = 64)
  (input logic          clk_i
  , input logic         arst_n_i
  , iter_unit_if.unit   u
  );

  typedef enum logic [1:0] {e_idle, e_busy, e_done} imul_state_e;

  localparam int cnt_width_lp = $clog2(width_p);

  imul_state_e state_r, state_n;
  logic [cnt_width_lp-1:0] cnt_r;

  logic [width_p-1:0]   mcand_r;  // multiplicand magnitude
  logic [2*width_p-1:0] acc_r;    // product high, multiplier low
  logic                 neg_r;

  logic                 start;
  logic                 last_step;
  logic                 a_neg;
  logic                 b_neg;
  logic [width_p-1:0]   mag_a;
  logic [width_p-1:0]   mag_b;
  logic [width_p:0]     hi_sum;
  logic [2*width_p-1:0] acc_step;

  assign start = u.v & u.ready;

  assign a_neg = u.signed_a & u.op_a[width_p-1];
  assign b_neg = u.signed_b & u.op_b[width_p-1];
  assign mag_a = a_neg ? -u.op_a : u.op_a;
  assign mag_b = b_neg ? -u.op_b : u.op_b;

  // --------------------
  // shift-add step
  // --------------------

  // add the multiplicand into the high half when the current multiplier bit is set,
  // then shift the whole accumulator right by one
  assign hi_sum   = {1'b0, acc_r[2*width_p-1:width_p]} + (acc_r[0] ? {1'b0, mcand_r} : '0);
  assign acc_step = {hi_sum, acc_r[width_p-1:1]};

  assign last_step = (state_r == e_busy) && (cnt_r == cnt_width_lp'(width_p-1));

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_idle: if (start) state_n = e_busy;
      e_busy: if (last_step) state_n = e_done;
      e_done: if (u.yumi) state_n = e_idle;
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (start)
        cnt_r <= '0;
      else if (state_r == e_busy)
        cnt_r <= cnt_r + 1'b1;  // one multiplier bit per cycle
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      mcand_r <= mag_a;
      acc_r   <= {{width_p{1'b0}}, mag_b};
      neg_r   <= a_neg ^ b_neg;
    end
    else if (state_r == e_busy)
      acc_r <= (last_step && neg_r) ? -acc_step : acc_step;  // sign folded into last step
  end

  // --------------------
  // outputs
  // --------------------

  assign u.ready  = (state_r == e_idle);
  assign u.res_v  = (state_r == e_done);
  assign u.res_lo = acc_r[width_p-1:0];
  assign u.res_hi = acc_r[2*width_p-1:width_p];

endmodule

// ==== source/iter_unit_if.sv ====
`timescale 1ns/10ps

interface iter_unit_if
  #(parameter int width_p = 64);

  logic               v;         // start strobe
  logic               ready;     // unit idle
  logic [width_p-1:0] op_a;
  logic [width_p-1:0] op_b;
  logic               signed_a;
  logic               signed_b;

  logic               res_v;     // held until yumi
  logic [width_p-1:0] res_lo;    // product low / quotient
  logic [width_p-1:0] res_hi;    // product high / remainder
  logic               yumi;

  modport requester
  (
    output v, op_a, op_b, signed_a, signed_b, yumi
    , input ready, res_v, res_lo, res_hi
  );

  modport unit
  (
    input v, op_a, op_b, signed_a, signed_b, yumi
    , output ready, res_v, res_lo, res_hi
  );

endinterface

// ==== source/long_pipe.sv ====
`timescale 1ns/10ps

module long_pipe
  (input logic                         clk_i
  , input logic                        arst_n_i

  , input logic                        v_i
  , input long_pipe_pkg::long_op_e     op_i
  , input logic                        opw_i
  , input long_pipe_pkg::dword_t       rs1_i
  , input long_pipe_pkg::dword_t       rs2_i
  , input long_pipe_pkg::rd_addr_t     rd_addr_i
  , output logic                       busy_o

  , output logic                       wb_v_o
  , output long_pipe_pkg::rd_addr_t    wb_rd_addr_o
  , output long_pipe_pkg::dword_t      wb_data_o
  , input logic                        wb_yumi_i

  , iter_unit_if.requester             mul_o
  , iter_unit_if.requester             div_o
  );

  import long_pipe_pkg::*;

  logic     accept;
  logic     is_mul;
  logic     word_op;
  logic     signed_div;
  dword_t   op_a;
  dword_t   op_b;

  long_op_e op_r;
  logic     opw_r;
  rd_addr_t rd_addr_r;
  logic     pending_r;

  logic     mul_sel;
  logic     wb_take;
  word_t    quo_w;

  // --------------------
  // decode
  // --------------------

  assign accept     = v_i & ~busy_o;
  assign is_mul     = op_i inside {e_mulh, e_mulhsu, e_mulhu};
  assign word_op    = opw_i & ~is_mul;  // no word form of mulh
  assign signed_div = op_i inside {e_div, e_rem};

  // word ops run at full width with operands in the upper half
  assign op_a = word_op ? (rs1_i << word_width_gp) : rs1_i;
  assign op_b = word_op ? (rs2_i << word_width_gp) : rs2_i;

  assign mul_o.v        = accept & is_mul;
  assign mul_o.op_a     = op_a;
  assign mul_o.op_b     = op_b;
  assign mul_o.signed_a = op_i inside {e_mulh, e_mulhsu};
  assign mul_o.signed_b = (op_i == e_mulh);

  assign div_o.v        = accept & ~is_mul;
  assign div_o.op_a     = op_a;
  assign div_o.op_b     = op_b;
  assign div_o.signed_a = signed_div;
  assign div_o.signed_b = signed_div;

  // --------------------
  // writeback register
  // --------------------

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_r      <= op_i;
      opw_r     <= word_op;
      rd_addr_r <= rd_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pending_r <= 1'b0;
    else if (accept)
      pending_r <= 1'b1;
    else if (wb_take)
      pending_r <= 1'b0;
  end

  assign mul_sel = op_r inside {e_mulh, e_mulhsu, e_mulhu};
  assign wb_v_o  = pending_r & (mul_sel ? mul_o.res_v : div_o.res_v);
  assign wb_take = wb_v_o & wb_yumi_i;

  // only the unit holding the result sees the yumi
  assign mul_o.yumi = wb_take & mul_sel;
  assign div_o.yumi = wb_take & ~mul_sel;

  // --------------------
  // result select
  // --------------------

  assign quo_w = div_o.res_lo[word_width_gp-1:0];

  always_comb
  begin
    if (mul_sel)
      wb_data_o = mul_o.res_hi;
    else if (opw_r && (op_r inside {e_div, e_divu}))
      wb_data_o = {{(dword_width_gp-word_width_gp){quo_w[word_width_gp-1]}}, quo_w};
    else if (opw_r)
      wb_data_o = $signed(div_o.res_hi) >>> word_width_gp;  // remainder sits in the upper word
    else if (op_r inside {e_div, e_divu})
      wb_data_o = div_o.res_lo;
    else
      wb_data_o = div_o.res_hi;
  end

  assign wb_rd_addr_o = rd_addr_r;

  // a unit leaving done also counts as busy
  assign busy_o = pending_r | ~mul_o.ready | ~div_o.ready;

endmodule

// ==== source/long_pipe_pkg.sv ====
package long_pipe_pkg;

  // --------------------
  // widths
  // --------------------

  localparam int dword_width_gp = 64;  // integer register file width
  localparam int word_width_gp  = 32;  // width of the *w ops

  localparam int rd_addr_width_gp = 5;

  // --------------------
  // value types
  // --------------------

  typedef logic [dword_width_gp-1:0]   dword_t;
  typedef logic [word_width_gp-1:0]    word_t;
  typedef logic [rd_addr_width_gp-1:0] rd_addr_t;

  // --------------------
  // long pipe ops
  // --------------------

  // mulh group goes to the multiplier, the rest to the divider
  typedef enum logic [2:0]
  {
    e_mulh   = 3'd0
    , e_mulhsu = 3'd1
    , e_mulhu  = 3'd2
    , e_div    = 3'd3
    , e_divu   = 3'd4
    , e_rem    = 3'd5
    , e_remu   = 3'd6
  } long_op_e;

endpackage

// ==== source/long_pipe_top.sv ====
`timescale 1ns/10ps

module long_pipe_top
  (input logic                         clk_i
  , input logic                        arst_n_i

  , input logic                        v_i
  , input long_pipe_pkg::long_op_e     op_i
  , input logic                        opw_i
  , input long_pipe_pkg::dword_t       rs1_i
  , input long_pipe_pkg::dword_t       rs2_i
  , input long_pipe_pkg::rd_addr_t     rd_addr_i
  , output logic                       busy_o

  , output logic                       wb_v_o
  , output long_pipe_pkg::rd_addr_t    wb_rd_addr_o
  , output long_pipe_pkg::dword_t      wb_data_o
  , input logic                        wb_yumi_i
  );

  import long_pipe_pkg::*;

  iter_unit_if #(.width_p(dword_width_gp)) mul_if ();
  iter_unit_if #(.width_p(dword_width_gp)) div_if ();

  long_pipe pipe_i
    (.clk_i        (clk_i)
    , .arst_n_i    (arst_n_i)
    , .v_i         (v_i)
    , .op_i        (op_i)
    , .opw_i       (opw_i)
    , .rs1_i       (rs1_i)
    , .rs2_i       (rs2_i)
    , .rd_addr_i   (rd_addr_i)
    , .busy_o      (busy_o)
    , .wb_v_o      (wb_v_o)
    , .wb_rd_addr_o(wb_rd_addr_o)
    , .wb_data_o   (wb_data_o)
    , .wb_yumi_i   (wb_yumi_i)
    , .mul_o       (mul_if.requester)
    , .div_o       (div_if.requester)
    );

  imul_iterative #(.width_p(dword_width_gp)) imul_i
    (.clk_i    (clk_i)
    , .arst_n_i(arst_n_i)
    , .u       (mul_if.unit)
    );

  idiv_iterative #(.width_p(dword_width_gp)) idiv_i
    (.clk_i    (clk_i)
    , .arst_n_i(arst_n_i)
    , .u       (div_if.unit)
    );

endmodule

// ==== tb/long_pipe_properties.sv ====
`timescale 1ns/10ps

module long_pipe_properties
  (input logic                       clk_i
  , input logic                      arst_n_i
  , input logic                      v_i
  , input logic                      busy_o
  , input logic                      wb_v_o
  , input long_pipe_pkg::rd_addr_t   wb_rd_addr_o
  , input long_pipe_pkg::dword_t     wb_data_o
  , input logic                      wb_yumi_i
  );

  int fail_count = 0;  // assertion failures so far
  int in_flight_r;     // accepted dispatches not yet written back

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      in_flight_r <= 0;
    else
      in_flight_r <= in_flight_r + int'(v_i && !busy_o) - int'(wb_v_o && wb_yumi_i);
  end

  // --------------------
  // dispatch side
  // --------------------

  no_dispatch_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    v_i |-> !busy_o)
    else
    begin
      $error("dispatch strobe seen while busy_o is high");
      fail_count++;
    end

  // --------------------
  // writeback side
  // --------------------

  wb_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (wb_v_o && !wb_yumi_i) |=> (wb_v_o && $stable(wb_data_o) && $stable(wb_rd_addr_o)))
    else
    begin
      $error("writeback outputs moved under back-pressure");
      fail_count++;
    end

  wb_needs_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_v_o |-> (in_flight_r > 0))
    else
    begin
      $error("wb_v_o high with no dispatch pending");
      fail_count++;
    end

endmodule

bind long_pipe long_pipe_properties props_i
  (.clk_i        (clk_i)
  , .arst_n_i    (arst_n_i)
  , .v_i         (v_i)
  , .busy_o      (busy_o)
  , .wb_v_o      (wb_v_o)
  , .wb_rd_addr_o(wb_rd_addr_o)
  , .wb_data_o   (wb_data_o)
  , .wb_yumi_i   (wb_yumi_i)
  );

// ==== tb/long_pipe_tb.sv ====
`timescale 1ns/10ps

module long_pipe_tb;

  import long_pipe_pkg::*;

  localparam int timeout_cycles = 300;

  logic     clk_i;
  logic     arst_n_i;
  logic     v_i;
  long_op_e op_i;
  logic     opw_i;
  dword_t   rs1_i;
  dword_t   rs2_i;
  rd_addr_t rd_addr_i;
  logic     busy_o;
  logic     wb_v_o;
  rd_addr_t wb_rd_addr_o;
  dword_t   wb_data_o;
  logic     wb_yumi_i;

  logic [31:0] lfsr_r;
  int          mismatch_count;
  int          timeout_count;
  int          protocol_count;

  dword_t   exp_data_q[$];
  rd_addr_t exp_rd_q[$];
  int       stall_q[$];  // yumi delay per item
  dword_t   ext_vals[4];

  long_pipe_top long_pipe_top_i
    (.clk_i        (clk_i)
    , .arst_n_i    (arst_n_i)
    , .v_i         (v_i)
    , .op_i        (op_i)
    , .opw_i       (opw_i)
    , .rs1_i       (rs1_i)
    , .rs2_i       (rs2_i)
    , .rd_addr_i   (rd_addr_i)
    , .busy_o      (busy_o)
    , .wb_v_o      (wb_v_o)
    , .wb_rd_addr_o(wb_rd_addr_o)
    , .wb_data_o   (wb_data_o)
    , .wb_yumi_i   (wb_yumi_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------
  // random source
  // --------------------

  function automatic logic lfsr_step();
    logic out;
    out    = lfsr_r[0];
    lfsr_r = lfsr_r >> 1;
    if (out)
      lfsr_r = lfsr_r ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[62:0], lfsr_step()};
    return r;
  endfunction

  // --------------------
  // reference model
  // --------------------

  function automatic dword_t long_op_ref(input long_op_e op, input logic opw,
                                          input dword_t a, input dword_t b);
    logic signed [127:0] ea;
    logic signed [127:0] eb;
    logic signed [127:0] full;
    dword_t              x;
    dword_t              y;
    dword_t              q;
    dword_t              r;
    logic                sgn;
    if (op inside {e_mulh, e_mulhsu, e_mulhu})
    begin
      ea   = (op != e_mulhu) ? {{64{a[63]}}, a} : {64'h0, a};
      eb   = (op == e_mulh) ? {{64{b[63]}}, b} : {64'h0, b};
      full = ea * eb;
      return full[127:64];  // word flag has no effect here
    end
    x   = opw ? (a << word_width_gp) : a;
    y   = opw ? (b << word_width_gp) : b;
    sgn = op inside {e_div, e_rem};
    if (y == '0)
    begin
      q = '1;
      r = x;
    end
    else if (sgn && (x == {1'b1, 63'h0}) && (y == '1))
    begin
      q = x;
      r = '0;
    end
    else if (sgn)
    begin
      ea   = {{64{x[63]}}, x};
      eb   = {{64{y[63]}}, y};
      full = ea / eb;
      q    = full[63:0];
      full = ea % eb;
      r    = full[63:0];
    end
    else
    begin
      q = x / y;
      r = x % y;
    end
    if (opw)
    begin
      q = {{32{q[31]}}, q[31:0]};
      r = $signed(r) >>> word_width_gp;
    end
    return (op inside {e_div, e_divu}) ? q : r;
  endfunction

  // --------------------
  // checks
  // --------------------

  task automatic check_data(input dword_t act, input dword_t exp);
    if (act !== exp)
    begin
      $display("MISMATCH wb_data_o: got %h, expected %h", act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_rd_addr(input rd_addr_t act, input rd_addr_t exp);
    if (act !== exp)
    begin
      $display("MISMATCH wb_rd_addr_o: got %h, expected %h", act, exp);
      mismatch_count++;
    end
  endtask

  // called 1 ns after a rising edge and returns at the same phase
  task automatic dispatch(input long_op_e op, input logic opw, input dword_t a,
                          input dword_t b, input int stall);
    int       waited;
    rd_addr_t rd;
    waited = 0;
    rd     = rd_addr_t'(rand_bits(5));
    if (timeout_count != 0)
      return;
    while (busy_o)
    begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > timeout_cycles)
      begin
        $display("ERROR: timed out waiting for busy_o to fall before a dispatch");
        timeout_count++;
        return;
      end
    end
    exp_data_q.push_back(long_op_ref(op, opw, a, b));
    exp_rd_q.push_back(rd);
    stall_q.push_back(stall);
    v_i       = 1'b1;
    op_i      = op;
    opw_i     = opw;
    rs1_i     = a;
    rs2_i     = b;
    rd_addr_i = rd;
    @(posedge clk_i);
    #1;
    v_i = 1'b0;
  endtask

  // --------------------
  // compare process
  // --------------------

  initial
  begin : compare_proc
    dword_t   held_data;
    rd_addr_t held_rd;
    int       stall;
    int       idle_cycles;
    idle_cycles = 0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (wb_v_o && (exp_data_q.size() == 0))
      begin
        $display("ERROR: writeback valid with no dispatch outstanding");
        protocol_count++;
      end
      else if (wb_v_o)
      begin
        held_data = exp_data_q.pop_front();
        held_rd   = exp_rd_q.pop_front();
        stall     = stall_q.pop_front();
        check_data(wb_data_o, held_data);
        check_rd_addr(wb_rd_addr_o, held_rd);
        for (int i = 0; i < stall; i++)
        begin
          @(posedge clk_i);
          #1;
          if (!wb_v_o || !busy_o)
          begin
            $display("ERROR: wb_v_o or busy_o dropped while the result was held back");
            protocol_count++;
          end
          check_data(wb_data_o, held_data);
          check_rd_addr(wb_rd_addr_o, held_rd);
        end
        wb_yumi_i = 1'b1;
        @(posedge clk_i);
        #1;
        wb_yumi_i   = 1'b0;
        idle_cycles = 0;
      end
      else if (exp_data_q.size() != 0)
      begin
        idle_cycles++;
        if (idle_cycles > timeout_cycles)
        begin
          $display("ERROR: timed out waiting for wb_v_o");
          timeout_count++;
          exp_data_q.delete();
          exp_rd_q.delete();
          stall_q.delete();
          idle_cycles = 0;
        end
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------

  initial
  begin : main_proc
    int     waited;
    int     assert_count;
    dword_t a;
    dword_t b;
    lfsr_r         = 32'hcf4;
    mismatch_count = 0;
    timeout_count  = 0;
    protocol_count = 0;
    arst_n_i       = 1'b0;
    v_i            = 1'b0;
    op_i           = e_mulh;
    opw_i          = 1'b0;
    rs1_i          = '0;
    rs2_i          = '0;
    rd_addr_i      = '0;
    wb_yumi_i      = 1'b0;
    ext_vals       = '{64'h0, '1, 64'h8000_0000_0000_0000, 64'h1};
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    if (busy_o !== 1'b0 || wb_v_o !== 1'b0)
    begin
      $display("ERROR: busy_o or wb_v_o not low after reset");
      protocol_count++;
    end

    // mulh on extremes and then random
    for (int op = 0; op < 3; op++)
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++)
          dispatch(long_op_e'(op), 1'b0, ext_vals[i], ext_vals[j], 0);
    for (int n = 0; n < 40; n++)
      dispatch(long_op_e'(rand_bits(2) % 3), 1'(rand_bits(1)), rand_bits(64),
               rand_bits(64), 0);

    // divide ops in both widths
    for (int n = 0; n < 80; n++)
    begin
      a = rand_bits(64);
      b = rand_bits(64) >> rand_bits(6);  // spread of quotient sizes
      dispatch(long_op_e'(3 + rand_bits(2)), 1'(rand_bits(1)), a, b, 0);
    end

    // divide by zero and signed overflow
    for (int op = 3; op < 7; op++)
      for (int w = 0; w < 2; w++)
      begin
        b = w ? {word_t'(rand_bits(32)), 32'h0} : 64'h0;
        dispatch(long_op_e'(op), 1'(w), rand_bits(64), b, 0);
        a = w ? {word_t'(rand_bits(32)), 32'h8000_0000} : 64'h8000_0000_0000_0000;
        dispatch(long_op_e'(op), 1'(w), a, b, 0);
        b = w ? {word_t'(rand_bits(32)), 32'hffff_ffff} : '1;
        dispatch(long_op_e'(op), 1'(w), a, b, 0);
      end

    // back-pressure on the writeback port
    for (int n = 0; n < 30; n++)
      dispatch(long_op_e'(rand_bits(3) % 7), 1'(rand_bits(1)), rand_bits(64), rand_bits(64),
               int'(rand_bits(4)));

    // issue as soon as busy_o falls
    for (int n = 0; n < 30; n++)
      dispatch(long_op_e'(rand_bits(3) % 7), 1'(rand_bits(1)), rand_bits(64),
               rand_bits(64), 0);

    waited = 0;
    while ((exp_data_q.size() != 0) || busy_o)
    begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > timeout_cycles)
      begin
        $display("ERROR: timed out waiting for the last writeback");
        timeout_count++;
        break;
      end
    end

    assert_count = long_pipe_top_i.pipe_i.props_i.fail_count;
    $display("errors: %0d mismatch, %0d timeout, %0d protocol, %0d assertion",
             mismatch_count, timeout_count, protocol_count, assert_count);
    if ((mismatch_count + timeout_count + protocol_count + assert_count) == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
